// ==== rtl/mem_profile_pkg.sv ====
/*
  Shared widths, word types and opcode encodings for the memory endpoint
  and its profiler. Modules reference these by scoped name.
*/

package mem_profile_pkg;

  localparam int data_width_lp  = 32;   // memory word and request/response data
  localparam int mem_words_lp   = 256;
  localparam int addr_width_lp  = 8;    // word address, log2 of mem_words_lp
  localparam int count_width_lp = 32;   // event counters and cycle count
  localparam int tag_width_lp   = 32;   // print-stat tag is one data word

  typedef logic [data_width_lp-1:0]  data_t;
  typedef logic [addr_width_lp-1:0]  addr_t;
  typedef logic [count_width_lp-1:0] count_t;
  typedef logic [tag_width_lp-1:0]   tag_t;

  // request opcode, 2'b11 is not issued
  typedef enum logic [1:0] {
    op_load  = 2'b00,
    op_store = 2'b01,
    op_amo   = 2'b10
  } req_op_e;

  // kind of atomic when the opcode is op_amo
  typedef enum logic [0:0] {
    amo_swap = 1'b0,
    amo_or   = 1'b1
  } amo_type_e;

  // endpoint FSM
  typedef enum logic [0:0] {
    idle      = 1'b0,
    amo_write = 1'b1   // second step of an atomic, memory busy
  } ep_state_e;

endpackage

// ==== rtl/mem_endpoint.sv ====
/*
  Memory endpoint. Accepts load, store and atomic requests on a 256-word
  memory and answers each accept with a one-cycle response pulse.
  Atomics read in the accept cycle and write back in the next one.
*/

`timescale 1ns/1ps

module mem_endpoint (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       req_v_i,
  input  mem_profile_pkg::req_op_e   req_op_i,
  input  mem_profile_pkg::amo_type_e req_amo_i,
  input  mem_profile_pkg::addr_t     req_addr_i,
  input  mem_profile_pkg::data_t     req_data_i,
  output logic                       req_yumi_o,

  output logic                       resp_v_o,
  output mem_profile_pkg::data_t     resp_data_o
);

  mem_profile_pkg::data_t     mem_r [mem_profile_pkg::mem_words_lp];
  mem_profile_pkg::ep_state_e state_r;
  mem_profile_pkg::ep_state_e state_n;
  mem_profile_pkg::addr_t     amo_addr_r;
  mem_profile_pkg::data_t     amo_data_r;
  mem_profile_pkg::data_t     rd_data;
  mem_profile_pkg::data_t     amo_new;
  logic                       accept;
  logic                       is_store;
  logic                       is_amo;
  logic                       resp_v_r;
  mem_profile_pkg::data_t     resp_data_r;

  assign req_yumi_o = req_v_i & (state_r == mem_profile_pkg::idle);
  assign accept     = req_v_i & req_yumi_o;
  assign is_store   = (req_op_i == mem_profile_pkg::op_store);
  assign is_amo     = (req_op_i == mem_profile_pkg::op_amo);
  assign rd_data    = mem_r[req_addr_i];   // async read sees last cycle's store

  always_comb begin
    case (req_amo_i)
      mem_profile_pkg::amo_swap: amo_new = req_data_i;
      default:                   amo_new = rd_data | req_data_i;
    endcase
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      mem_profile_pkg::idle: begin
        if (accept && is_amo) state_n = mem_profile_pkg::amo_write;
      end
      default: state_n = mem_profile_pkg::idle;   // write-back takes one cycle
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= mem_profile_pkg::idle;
      resp_v_r <= 1'b0;
    end else begin
      state_r  <= state_n;
      resp_v_r <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && is_store) begin
      mem_r[req_addr_i] <= req_data_i;
    end else if (state_r == mem_profile_pkg::amo_write) begin
      mem_r[amo_addr_r] <= amo_data_r;
    end
  end

  // atomic operands held over into amo_write
  always_ff @(posedge clk_i) begin
    if (accept && is_amo) begin
      amo_addr_r <= req_addr_i;
      amo_data_r <= amo_new;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_data_r <= is_store ? '0 : rd_data;   // load and amo return the old word
    end
  end

  assign resp_v_o    = resp_v_r;
  assign resp_data_o = resp_data_r;

  a_amo_blocks_next: assert property (@(posedge clk_i) disable iff (reset_i)
    (accept && is_amo) |=> !req_yumi_o);

endmodule

// ==== rtl/op_profiler.sv ====
/*
  Request profiler. Counts accepted loads, stores, swaps and ORs and runs
  a cycle counter. A print-stat strobe registers one snapshot, which
  includes an accept in the strobe cycle, and pulses stat_v_o.
*/

`timescale 1ns/1ps

module op_profiler (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       acc_i,
  input  mem_profile_pkg::req_op_e   op_i,
  input  mem_profile_pkg::amo_type_e amo_i,

  input  logic                       print_stat_v_i,
  input  mem_profile_pkg::tag_t      print_stat_tag_i,

  output logic                       stat_v_o,
  output mem_profile_pkg::tag_t      stat_tag_o,
  output mem_profile_pkg::count_t    stat_cycle_o,
  output mem_profile_pkg::count_t    stat_ld_o,
  output mem_profile_pkg::count_t    stat_st_o,
  output mem_profile_pkg::count_t    stat_amoswap_o,
  output mem_profile_pkg::count_t    stat_amoor_o
);

  logic                    is_amo;
  logic [3:0]              inc;   // {amoor, amoswap, st, ld}
  mem_profile_pkg::count_t cnt_r  [4];
  mem_profile_pkg::count_t snap_r [4];
  mem_profile_pkg::count_t cycle_r;
  mem_profile_pkg::count_t snap_cycle_r;
  mem_profile_pkg::tag_t   snap_tag_r;
  logic                    stat_v_r;

  assign is_amo = (op_i == mem_profile_pkg::op_amo);
  assign inc[0] = acc_i & (op_i == mem_profile_pkg::op_load);
  assign inc[1] = acc_i & (op_i == mem_profile_pkg::op_store);
  assign inc[2] = acc_i & is_amo & (amo_i == mem_profile_pkg::amo_swap);
  assign inc[3] = acc_i & is_amo & (amo_i == mem_profile_pkg::amo_or);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 4; i++) begin
        cnt_r[i] <= '0;
      end
      cycle_r  <= '0;
      stat_v_r <= 1'b0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        cnt_r[i] <= cnt_r[i] + mem_profile_pkg::count_t'(inc[i]);
      end
      cycle_r  <= cycle_r + 1'b1;   // zero during the first cycle after reset
      stat_v_r <= print_stat_v_i;
    end
  end

  // snapshot folds in this cycle's accept
  always_ff @(posedge clk_i) begin
    if (print_stat_v_i) begin
      for (int i = 0; i < 4; i++) begin
        snap_r[i] <= cnt_r[i] + mem_profile_pkg::count_t'(inc[i]);
      end
      snap_cycle_r <= cycle_r;
      snap_tag_r   <= print_stat_tag_i;
    end
  end

  assign stat_v_o       = stat_v_r;
  assign stat_tag_o     = snap_tag_r;
  assign stat_cycle_o   = snap_cycle_r;
  assign stat_ld_o      = snap_r[0];
  assign stat_st_o      = snap_r[1];
  assign stat_amoswap_o = snap_r[2];
  assign stat_amoor_o   = snap_r[3];

endmodule

// ==== rtl/mem_profile_top.sv ====
/*
  Top level of the memory endpoint with profiler. The endpoint serves the
  request stream and the profiler watches the same accept strobe.
*/

`timescale 1ns/1ps

module mem_profile_top (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       req_v_i,
  input  mem_profile_pkg::req_op_e   req_op_i,
  input  mem_profile_pkg::amo_type_e req_amo_i,
  input  mem_profile_pkg::addr_t     req_addr_i,
  input  mem_profile_pkg::data_t     req_data_i,
  output logic                       req_yumi_o,

  output logic                       resp_v_o,
  output mem_profile_pkg::data_t     resp_data_o,

  input  logic                       print_stat_v_i,
  input  mem_profile_pkg::tag_t      print_stat_tag_i,
  output logic                       stat_v_o,
  output mem_profile_pkg::tag_t      stat_tag_o,
  output mem_profile_pkg::count_t    stat_cycle_o,
  output mem_profile_pkg::count_t    stat_ld_o,
  output mem_profile_pkg::count_t    stat_st_o,
  output mem_profile_pkg::count_t    stat_amoswap_o,
  output mem_profile_pkg::count_t    stat_amoor_o
);

  logic yumi;   // endpoint accept, also seen by the profiler

  mem_endpoint u_endpoint (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (req_v_i),
    .req_op_i    (req_op_i),
    .req_amo_i   (req_amo_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .req_yumi_o  (yumi),
    .resp_v_o    (resp_v_o),
    .resp_data_o (resp_data_o)
  );

  assign req_yumi_o = yumi;

  // yumi only rises with req_v_i, so it is the accept on its own
  op_profiler u_profiler (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .acc_i            (yumi),
    .op_i             (req_op_i),
    .amo_i            (req_amo_i),
    .print_stat_v_i   (print_stat_v_i),
    .print_stat_tag_i (print_stat_tag_i),
    .stat_v_o         (stat_v_o),
    .stat_tag_o       (stat_tag_o),
    .stat_cycle_o     (stat_cycle_o),
    .stat_ld_o        (stat_ld_o),
    .stat_st_o        (stat_st_o),
    .stat_amoswap_o   (stat_amoswap_o),
    .stat_amoor_o     (stat_amoor_o)
  );

endmodule

// ==== dv/mem_profile_tb.sv ====
/*
  Testbench for the memory endpoint with profiler. Fills the memory, then
  runs seeded random traffic with print-stat strobes, and checks every
  response and snapshot against a model that watches the DUT ports.
*/

`timescale 1ns/1ps

module mem_profile_tb;

  localparam int run_cycles_lp     = 2000;
  localparam int timeout_cycles_lp = mem_profile_pkg::mem_words_lp + run_cycles_lp + 500;

  logic                       clk_i;
  logic                       reset_i;
  logic                       req_v_i;
  mem_profile_pkg::req_op_e   req_op_i;
  mem_profile_pkg::amo_type_e req_amo_i;
  mem_profile_pkg::addr_t     req_addr_i;
  mem_profile_pkg::data_t     req_data_i;
  logic                       req_yumi_o;
  logic                       resp_v_o;
  mem_profile_pkg::data_t     resp_data_o;
  logic                       print_stat_v_i;
  mem_profile_pkg::tag_t      print_stat_tag_i;
  logic                       stat_v_o;
  mem_profile_pkg::tag_t      stat_tag_o;
  mem_profile_pkg::count_t    stat_cycle_o;
  mem_profile_pkg::count_t    stat_ld_o;
  mem_profile_pkg::count_t    stat_st_o;
  mem_profile_pkg::count_t    stat_amoswap_o;
  mem_profile_pkg::count_t    stat_amoor_o;

  // model state
  mem_profile_pkg::data_t  mirror [mem_profile_pkg::mem_words_lp];
  mem_profile_pkg::data_t  exp_q [$];   // response owed at the next edge
  mem_profile_pkg::count_t m_ld = '0;
  mem_profile_pkg::count_t m_st = '0;
  mem_profile_pkg::count_t m_swap = '0;
  mem_profile_pkg::count_t m_or = '0;
  mem_profile_pkg::count_t m_cycle = '0;
  mem_profile_pkg::tag_t   exp_tag;
  mem_profile_pkg::count_t exp_cycle;
  mem_profile_pkg::count_t exp_ld;
  mem_profile_pkg::count_t exp_st;
  mem_profile_pkg::count_t exp_swap;
  mem_profile_pkg::count_t exp_or;
  logic                    stat_pend = 1'b0;
  logic                    amo_prev = 1'b0;
  int                      tb_cycles = 0;

  mem_profile_top DUT (.*);

  always #5 clk_i = ~clk_i;

  task automatic stop_failed();
    $display("Test failed");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    stop_failed();
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_data(input string name, input mem_profile_pkg::data_t got,
                            input mem_profile_pkg::data_t exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_count(input string name, input mem_profile_pkg::count_t got,
                             input mem_profile_pkg::count_t exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_tag(input string name, input mem_profile_pkg::tag_t got,
                           input mem_profile_pkg::tag_t exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      stop_failed();
    end
  endtask

  // called on a rising edge, returns on the edge of the accept
  task automatic send_store(input mem_profile_pkg::addr_t addr, input mem_profile_pkg::data_t data);
    req_v_i    <= 1'b1;
    req_op_i   <= mem_profile_pkg::op_store;
    req_addr_i <= addr;
    req_data_i <= data;
    @(posedge clk_i);
    while (!req_yumi_o) @(posedge clk_i);
  endtask

  task automatic pick_request();
    req_v_i <= 1'b1;
    case ($urandom % 3)
      0:       req_op_i <= mem_profile_pkg::op_load;
      1:       req_op_i <= mem_profile_pkg::op_store;
      default: req_op_i <= mem_profile_pkg::op_amo;
    endcase
    req_amo_i  <= ($urandom % 2 == 0) ? mem_profile_pkg::amo_swap : mem_profile_pkg::amo_or;
    req_addr_i <= mem_profile_pkg::addr_t'($urandom % 64);   // narrow window, words get reused
    req_data_i <= $urandom;
  endtask

  // model and checks, on values that settled before the edge
  always @(posedge clk_i) begin
    mem_profile_pkg::data_t old_word;
    tb_cycles = tb_cycles + 1;
    if (tb_cycles > timeout_cycles_lp) begin
      abort_run($sformatf("timeout, the run did not finish within %0d cycles", timeout_cycles_lp));
    end
    if (reset_i) begin
      check_flag("req_yumi_o", req_yumi_o, 1'b0);
    end else begin
      check_flag("resp_v_o", resp_v_o, exp_q.size() != 0);
      if (resp_v_o) check_data("resp_data_o", resp_data_o, exp_q.pop_front());
      if (amo_prev || !req_v_i) check_flag("req_yumi_o", req_yumi_o, 1'b0);
      check_flag("stat_v_o", stat_v_o, stat_pend);
      if (stat_pend) begin
        check_tag("stat_tag_o", stat_tag_o, exp_tag);
        check_count("stat_cycle_o", stat_cycle_o, exp_cycle);
        check_count("stat_ld_o", stat_ld_o, exp_ld);
        check_count("stat_st_o", stat_st_o, exp_st);
        check_count("stat_amoswap_o", stat_amoswap_o, exp_swap);
        check_count("stat_amoor_o", stat_amoor_o, exp_or);
      end
      amo_prev = 1'b0;
      if (req_v_i && req_yumi_o) begin
        old_word = mirror[req_addr_i];
        case (req_op_i)
          mem_profile_pkg::op_load: begin
            exp_q.push_back(old_word);
            m_ld = m_ld + 1;
          end
          mem_profile_pkg::op_store: begin
            exp_q.push_back('0);
            mirror[req_addr_i] = req_data_i;
            m_st = m_st + 1;
          end
          default: begin
            exp_q.push_back(old_word);
            amo_prev = 1'b1;
            if (req_amo_i == mem_profile_pkg::amo_swap) begin
              mirror[req_addr_i] = req_data_i;
              m_swap = m_swap + 1;
            end else begin
              mirror[req_addr_i] = old_word | req_data_i;
              m_or = m_or + 1;
            end
          end
        endcase
      end
      stat_pend = print_stat_v_i;   // snapshot includes this edge's accept
      if (print_stat_v_i) begin
        exp_tag   = print_stat_tag_i;
        exp_cycle = m_cycle;
        exp_ld    = m_ld;
        exp_st    = m_st;
        exp_swap  = m_swap;
        exp_or    = m_or;
      end
      m_cycle = m_cycle + 1;
    end
  end

  initial begin
    void'($urandom(11));
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    req_v_i          = 1'b0;
    req_op_i         = mem_profile_pkg::op_load;
    req_amo_i        = mem_profile_pkg::amo_swap;
    req_addr_i       = '0;
    req_data_i       = '0;
    print_stat_v_i   = 1'b0;
    print_stat_tag_i = '0;
    repeat (3) @(posedge clk_i);
    reset_i          <= 1'b0;
    print_stat_v_i   <= 1'b1;   // first snapshot, all counts still zero
    print_stat_tag_i <= $urandom;
    @(posedge clk_i);
    print_stat_v_i <= 1'b0;

    for (int i = 0; i < mem_profile_pkg::mem_words_lp; i++) begin
      send_store(mem_profile_pkg::addr_t'(i), $urandom);
    end

    for (int c = 0; c < run_cycles_lp; c++) begin
      print_stat_v_i   <= ($urandom % 100) < 5;
      print_stat_tag_i <= $urandom;
      if (!req_v_i || req_yumi_o) begin
        if (($urandom % 100) < 70) pick_request();
        else req_v_i <= 1'b0;
      end
      @(posedge clk_i);
    end
    print_stat_v_i <= 1'b0;
    while (req_v_i && !req_yumi_o) @(posedge clk_i);
    req_v_i <= 1'b0;

    // drain the last response and snapshot
    do @(negedge clk_i); while (exp_q.size() != 0 || stat_pend);
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== mem_profile.f ====
rtl/mem_profile_pkg.sv
rtl/mem_endpoint.sv
rtl/op_profiler.sv
rtl/mem_profile_top.sv
dv/mem_profile_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it, the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f mem_profile.f --top-module mem_profile_tb \
  -o sim_mem_profile &&
./obj_dir/sim_mem_profile ||
{ echo "simulation did not complete cleanly"; exit 1; }
